// ==== compile.f ====
hw/duck_display_pkg.sv
hw/vga_timing.sv
hw/sprite_rom.sv
hw/shot_counter.sv
hw/color_mapper.sv
hw/game_display.sv
verification/display_checker.sv
verification/tb_game_display.sv

// ==== Makefile ====
# Verilator build and run for the game display testbench

VERILATOR ?= verilator
TOP       ?= tb_game_display
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG := All tests passed!
SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# verdict comes from the log, not from the exit code of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_game_display.sv ====
`timescale 1ns/1ns

module tb_game_display;
	import duck_display_pkg::*;

	localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
	// the sequence below runs a little over ten frames
	localparam int TEST_FRAMES = 11;
	localparam int TIMEOUT_CYCLES = (TEST_FRAMES + 1) * FRAME_CYCLES;
	localparam int NUM_TESTS = 6;

	logic vga_clk;
	logic reset;
	coord_t ball_x;
	coord_t ball_y;
	coord_t ball_size;
	coord_t dog_x;
	coord_t dog_y;
	frame_t dog_frame;
	logic fire;
	color_t red;
	color_t green;
	color_t blue;
	logic hsync;
	logic vsync;
	int test_id;
	int error_count;
	int check_count;
	int cycle_count = 0;
	logic [15:0] lfsr;

	game_display uut (
		.vga_clk (vga_clk), .reset (reset),
		.ball_x (ball_x), .ball_y (ball_y), .ball_size (ball_size),
		.dog_x (dog_x), .dog_y (dog_y), .dog_frame (dog_frame), .fire (fire),
		.red (red), .green (green), .blue (blue), .hsync (hsync), .vsync (vsync)
	);

	display_checker chk (
		.vga_clk (vga_clk), .reset (reset),
		.ball_x (ball_x), .ball_y (ball_y), .ball_size (ball_size),
		.dog_x (dog_x), .dog_y (dog_y), .dog_frame (dog_frame), .fire (fire),
		.red (red), .green (green), .blue (blue), .hsync (hsync), .vsync (vsync),
		.test_id (test_id), .error_count (error_count), .check_count (check_count)
	);

	// 20 ns pixel clock
	initial
		vga_clk = 1'b0;
	always #10 vga_clk = ~vga_clk;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	// 16 bit fibonacci with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// start of vsync then on to the drive point of the next cycle
	task automatic wait_vblank();
		@(negedge vsync);
		@(posedge vga_clk);
		#2;
	endtask

	// cursor and dog off the picture
	task automatic park_sprites();
		ball_x = 10'd1000;
		ball_y = 10'd1000;
		ball_size = 10'd4;
		dog_x = 10'd900;
		dog_y = 10'd900;
	endtask

	task automatic pulse_fire();
		fire = 1'b1;
		repeat (4) @(posedge vga_clk);
		#2;
		fire = 1'b0;
	endtask

	// hang guard
	always @(posedge vga_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial
	begin
		int value;
		lfsr = 16'd60;
		reset = 1'b1;
		fire = 1'b0;
		dog_frame = 1'b0;
		test_id = 0;
		park_sprites();
		repeat (3) @(posedge vga_clk);
		#2;
		reset = 1'b0;
		// sync and blank over the first frame
		test_id = 1;
		wait_vblank();
		// plain background and full ammo
		test_id = 2;
		wait_vblank();
		// random diamond cursor
		test_id = 3;
		random_bits(10, value);
		ball_x = coord_t'(value % 640);
		random_bits(9, value);
		ball_y = coord_t'(value % 480);
		random_bits(5, value);
		ball_size = coord_t'(value + 6);
		wait_vblank();
		// dog in both frames with the cursor on its centre
		test_id = 4;
		random_bits(10, value);
		dog_x = coord_t'(value % 600);
		random_bits(9, value);
		dog_y = coord_t'(value % 320);
		ball_x = dog_x + 10'd16;
		ball_y = dog_y + 10'd12;
		ball_size = 10'd6;
		wait_vblank();
		dog_frame = 1'b1;
		wait_vblank();
		// shots from pulse, hold, pulse and one pulse past saturation
		test_id = 5;
		dog_frame = 1'b0;
		ball_x = 10'd1000;
		pulse_fire();
		wait_vblank();
		fire = 1'b1;
		wait_vblank();
		fire = 1'b0;
		repeat (2) @(posedge vga_clk);
		#2;
		pulse_fire();
		wait_vblank();
		pulse_fire();
		wait_vblank();
		// reset halfway down the picture
		test_id = 6;
		repeat (FRAME_CYCLES / 2) @(posedge vga_clk);
		#2;
		reset = 1'b1;
		repeat (3) @(posedge vga_clk);
		#2;
		reset = 1'b0;
		wait_vblank();
		test_id = 0;
		// last compare and test line happen on this falling edge
		@(negedge vga_clk);
		@(posedge vga_clk);
		$display("%0d tests, %0d checks, %0d mismatches", NUM_TESTS, check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== verification/display_checker.sv ====
`timescale 1ns/1ns

module display_checker (
	input  logic                      vga_clk,
	input  logic                      reset,
	input  duck_display_pkg::coord_t  ball_x,
	input  duck_display_pkg::coord_t  ball_y,
	input  duck_display_pkg::coord_t  ball_size,
	input  duck_display_pkg::coord_t  dog_x,
	input  duck_display_pkg::coord_t  dog_y,
	input  duck_display_pkg::frame_t  dog_frame,
	input  logic                      fire,
	input  duck_display_pkg::color_t  red,
	input  duck_display_pkg::color_t  green,
	input  duck_display_pkg::color_t  blue,
	input  logic                      hsync,
	input  logic                      vsync,
	input  int                        test_id,
	output int                        error_count,
	output int                        check_count
);
	import duck_display_pkg::*;

	localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

	// reset as sampled by the last rising edge
	logic rst_prev;
	// cycles since reset release
	int cycle;
	// shot count from our own view of the button
	int exp_shots;
	logic fire_last;
	int cur_test;
	int test_errors;

	// ------------------------------------------------------------
	// reference pixel, priority cursor > dog > square > background
	// ------------------------------------------------------------
	function automatic logic [11:0] expected_pixel(input int x, input int y, input int shots);
		int dx;
		int dy;
		int col;
		int row;
		int idx;
		if (x >= int'(H_VISIBLE) || y >= int'(V_VISIBLE))
			return 12'h000;
		dx = (x >= int'(ball_x)) ? x - int'(ball_x) : int'(ball_x) - x;
		dy = (y >= int'(ball_y)) ? y - int'(ball_y) : int'(ball_y) - y;
		if (dx + dy <= int'(ball_size))
			return CURSOR_COLOR;
		col = x - int'(dog_x);
		row = y - int'(dog_y);
		// stripe pattern, clear two columns at each side
		if (col >= 2 && col <= 29 && row >= 0 && row < int'(DOG_H))
		begin
			idx = (col / 4 + row / 4 + int'(dog_frame)) % 8;
			if (idx != 0)
				return DOG_PALETTE[idx];
		end
		// square n gone once shots reach 4 - n
		for (int n = 1; n <= 3; n++)
		begin
			if (x >= int'(SQ_X0[n - 1]) && x < int'(SQ_X0[n - 1]) + 9
				&& y >= int'(SQ_Y0) && y < int'(SQ_Y1) && shots < 4 - n)
				return SQUARE_COLOR;
		end
		if (y < int'(HORIZON_Y))
			return SKY_COLOR;
		return GRASS_COLOR;
	endfunction

	task automatic check_value(input string name, input logic [3:0] exp, input logic [3:0] act,
		input int x, input int y);
		check_count = check_count + 1;
		if (act !== exp)
		begin
			error_count = error_count + 1;
			if (x < 0)
				$display("MISMATCH %s during reset: expected %h, got %h", name, exp, act);
			else
				$display("MISMATCH %s at x=%0d y=%0d: expected %h, got %h", name, x, y, exp, act);
		end
	endtask

	initial
	begin
		rst_prev = 1'b1;
		cycle = 0;
		exp_shots = 0;
		fire_last = 1'b0;
		cur_test = 0;
		test_errors = 0;
		error_count = 0;
		check_count = 0;
	end

	// ------------------------------------------------------------
	// compare at the falling edge, outputs settled
	// ------------------------------------------------------------
	always @(negedge vga_clk)
	begin
		int pos;
		int x;
		int y;
		logic [11:0] exp_rgb;
		if (rst_prev)
		begin
			// pipeline and counters cleared
			cycle = 0;
			exp_shots = 0;
			fire_last = 1'b0;
			check_value("red", 4'h0, red, -1, -1);
			check_value("green", 4'h0, green, -1, -1);
			check_value("blue", 4'h0, blue, -1, -1);
			check_value("hsync", 4'h1, {3'b000, hsync}, -1, -1);
			check_value("vsync", 4'h1, {3'b000, vsync}, -1, -1);
		end
		else
		begin
			cycle = cycle + 1;
			// pins show the coordinate two cycles back
			pos = (cycle - PIXEL_LATENCY + FRAME_CYCLES) % FRAME_CYCLES;
			x = pos % int'(H_TOTAL);
			y = pos / int'(H_TOTAL);
			exp_rgb = expected_pixel(x, y, exp_shots);
			check_value("red", exp_rgb[11:8], red, x, y);
			check_value("green", exp_rgb[7:4], green, x, y);
			check_value("blue", exp_rgb[3:0], blue, x, y);
			// sync windows, active low
			check_value("hsync", {3'b000, !(x >= 656 && x < 752)}, {3'b000, hsync}, x, y);
			check_value("vsync", {3'b000, !(y >= 490 && y < 492)}, {3'b000, vsync}, x, y);
			// held button counts once, saturates at three
			if (fire && !fire_last && exp_shots < 3)
				exp_shots = exp_shots + 1;
			fire_last = fire;
		end
		rst_prev = reset;
		// report a test as the sequence moves on
		if (test_id != cur_test)
		begin
			if (cur_test != 0)
				$display("test %0d done: %0d mismatches", cur_test, error_count - test_errors);
			cur_test = test_id;
			test_errors = error_count;
		end
	end

endmodule

// ==== hw/game_display.sv ====
`timescale 1ns/1ns

module game_display (
	input  logic                      vga_clk,
	input  logic                      reset,
	input  duck_display_pkg::coord_t  ball_x,
	input  duck_display_pkg::coord_t  ball_y,
	input  duck_display_pkg::coord_t  ball_size,
	input  duck_display_pkg::coord_t  dog_x,
	input  duck_display_pkg::coord_t  dog_y,
	input  duck_display_pkg::frame_t  dog_frame,
	input  logic                      fire,
	output duck_display_pkg::color_t  red,
	output duck_display_pkg::color_t  green,
	output duck_display_pkg::color_t  blue,
	output logic                      hsync,
	output logic                      vsync
);
	import duck_display_pkg::*;

	// raster position and blank
	coord_t draw_x;
	coord_t draw_y;
	logic visible;
	// sprite rom link
	logic [10:0] dog_addr;
	pal_index_t dog_index;
	// ammo used
	shot_count_t shots;

	// ------------------------------------------------------------
	// raster and syncs
	// ------------------------------------------------------------
	vga_timing timing (
		.vga_clk (vga_clk),
		.reset   (reset),
		.draw_x  (draw_x),
		.draw_y  (draw_y),
		.visible (visible),
		.hsync   (hsync),
		.vsync   (vsync)
	);

	// mouse button to shot count
	shot_counter shot_cnt (
		.vga_clk (vga_clk),
		.reset   (reset),
		.fire    (fire),
		.shots   (shots)
	);

	// ------------------------------------------------------------
	// pixel pipeline
	// ------------------------------------------------------------
	color_mapper mapper (
		.vga_clk   (vga_clk),
		.reset     (reset),
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.visible   (visible),
		.ball_x    (ball_x),
		.ball_y    (ball_y),
		.ball_size (ball_size),
		.dog_x     (dog_x),
		.dog_y     (dog_y),
		.dog_frame (dog_frame),
		.shots     (shots),
		.dog_index (dog_index),
		.dog_addr  (dog_addr),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

	sprite_rom dog_rom (
		.vga_clk (vga_clk),
		.addr    (dog_addr),
		.index   (dog_index)
	);

endmodule

// ==== hw/color_mapper.sv ====
`timescale 1ns/1ns

module color_mapper (
	input  logic                           vga_clk,
	input  logic                           reset,
	input  duck_display_pkg::coord_t       draw_x,
	input  duck_display_pkg::coord_t       draw_y,
	input  logic                           visible,
	input  duck_display_pkg::coord_t       ball_x,
	input  duck_display_pkg::coord_t       ball_y,
	input  duck_display_pkg::coord_t       ball_size,
	input  duck_display_pkg::coord_t       dog_x,
	input  duck_display_pkg::coord_t       dog_y,
	input  duck_display_pkg::frame_t       dog_frame,
	input  duck_display_pkg::shot_count_t  shots,
	input  duck_display_pkg::pal_index_t   dog_index,
	output logic [10:0]                    dog_addr,
	output duck_display_pkg::color_t       red,
	output duck_display_pkg::color_t       green,
	output duck_display_pkg::color_t       blue
);
	import duck_display_pkg::*;

	// cursor distance terms, one extra bit for the sign
	logic signed [10:0] dist_x;
	logic signed [10:0] dist_y;
	logic [10:0] abs_x;
	logic [10:0] abs_y;
	logic [11:0] dist_sum;
	// stage 1 hit tests
	logic cursor_hit;
	logic dog_hit;
	logic square_hit;
	// texel position inside dog box
	logic [4:0] dog_col;
	logic [4:0] dog_row;
	// stage 1 registers
	logic visible_s1;
	logic cursor_s1;
	logic dog_s1;
	logic square_s1;
	logic sky_s1;
	// stage 2 pixel
	rgb_t pixel_next;
	rgb_t pixel_q;

	// ------------------------------------------------------------
	// stage 1: hit tests
	// ------------------------------------------------------------
	// diamond cursor, |dx| + |dy| <= size
	assign dist_x = $signed({1'b0, draw_x}) - $signed({1'b0, ball_x});
	assign dist_y = $signed({1'b0, draw_y}) - $signed({1'b0, ball_y});
	assign abs_x = dist_x[10] ? -dist_x : dist_x;
	assign abs_y = dist_y[10] ? -dist_y : dist_y;
	assign dist_sum = {1'b0, abs_x} + {1'b0, abs_y};
	assign cursor_hit = dist_sum <= {2'b00, ball_size};

	// dog box, widened compare so a far edge does not wrap
	assign dog_hit = ({1'b0, draw_x} >= {1'b0, dog_x})
		&& ({1'b0, draw_x} < {1'b0, dog_x} + {1'b0, DOG_W})
		&& ({1'b0, draw_y} >= {1'b0, dog_y})
		&& ({1'b0, draw_y} < {1'b0, dog_y} + {1'b0, DOG_H});

	assign dog_col = 5'(draw_x - dog_x);
	assign dog_row = 5'(draw_y - dog_y);

	// rom address, frame base + row * 32 + col
	// parked at 0 outside the box
	assign dog_addr = dog_hit
		? (dog_frame ? 11'(DOG_FRAME_WORDS) : 11'd0) + {1'b0, dog_row, dog_col}
		: '0;

	// ammo squares, square n kept while shots < 4 - n
	always_comb
	begin
		square_hit = 1'b0;
		for (int i = 0; i < 3; i++)
		begin
			if (draw_x >= SQ_X0[i] && draw_x < SQ_X0[i] + SQ_W
				&& draw_y >= SQ_Y0 && draw_y < SQ_Y1
				&& shots < shot_count_t'(3 - i))
				square_hit = 1'b1;
		end
	end

	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			visible_s1 <= 1'b0;
			cursor_s1 <= 1'b0;
			dog_s1 <= 1'b0;
			square_s1 <= 1'b0;
			sky_s1 <= 1'b0;
		end
		else
		begin
			visible_s1 <= visible;
			cursor_s1 <= cursor_hit;
			dog_s1 <= dog_hit;
			square_s1 <= square_hit;
			// banded background, sky above horizon
			sky_s1 <= draw_y < HORIZON_Y;
		end
	end

	// ------------------------------------------------------------
	// stage 2: priority select
	// ------------------------------------------------------------
	// dog_index arrives now, rom was addressed in stage 1
	always_comb
	begin
		if (!visible_s1)
			pixel_next = '0;
		else if (cursor_s1)
			pixel_next = CURSOR_COLOR;
		else if (dog_s1 && dog_index != '0)
			pixel_next = DOG_PALETTE[dog_index];
		else if (square_s1)
			pixel_next = SQUARE_COLOR;
		else if (sky_s1)
			pixel_next = SKY_COLOR;
		else
			pixel_next = GRASS_COLOR;
	end

	always_ff @(posedge vga_clk)
	begin
		if (reset)
			pixel_q <= '0;
		else
			pixel_q <= pixel_next;
	end

	assign red = pixel_q[11:8];
	assign green = pixel_q[7:4];
	assign blue = pixel_q[3:0];

	// blanked pixel leaves the pipe as black
	assert property (@(posedge vga_clk) disable iff (reset)
		!visible_s1 |=> {red, green, blue} == '0);

endmodule

// ==== hw/shot_counter.sv ====
`timescale 1ns/1ns

module shot_counter (
	input  logic                           vga_clk,
	input  logic                           reset,
	input  logic                           fire,
	output duck_display_pkg::shot_count_t  shots
);
	import duck_display_pkg::*;

	// registered button and its previous sample
	logic fire_q;
	logic fire_prev;
	logic fire_rise;

	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			fire_q <= 1'b0;
			fire_prev <= 1'b0;
		end
		else
		begin
			fire_q <= fire;
			fire_prev <= fire_q;
		end
	end

	// one pulse per press, a held button counts once
	assign fire_rise = fire_q && !fire_prev;

	// saturating shot count
	always_ff @(posedge vga_clk)
	begin
		if (reset)
			shots <= '0;
		else if (fire_rise && shots != 2'd3)
			shots <= shots + 1'b1;
	end

	// ammo is only refilled by reset
	assert property (@(posedge vga_clk) disable iff (reset) shots >= $past(shots));

endmodule

// ==== hw/sprite_rom.sv ====
`timescale 1ns/1ns

module sprite_rom (
	input  logic                          vga_clk,
	input  logic [10:0]                   addr,
	output duck_display_pkg::pal_index_t  index
);
	import duck_display_pkg::*;

	// two frames, row major, 32 words per row
	pal_index_t mem [DOG_ROM_DEPTH];

	// ------------------------------------------------------------
	// pattern fill
	// ------------------------------------------------------------
	// diagonal 4x4 stripes, shifted by one palette step per frame
	initial
	begin
		for (int f = 0; f < 2; f++)
		begin
			for (int r = 0; r < DOG_H; r++)
			begin
				for (int c = 0; c < DOG_W; c++)
				begin
					// two clear columns each side
					if (c < 2 || c > 29)
						mem[f * DOG_FRAME_WORDS + r * DOG_W + c] = '0;
					else
						mem[f * DOG_FRAME_WORDS + r * DOG_W + c] =
							pal_index_t'((c / 4 + r / 4 + f) % 8);
				end
			end
		end
	end

	// ------------------------------------------------------------
	// registered read
	// ------------------------------------------------------------
	// one cycle from address to index
	always_ff @(posedge vga_clk)
	begin
		index <= mem[addr];
	end

endmodule

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing (
	input  logic                      vga_clk,
	input  logic                      reset,
	output duck_display_pkg::coord_t  draw_x,
	output duck_display_pkg::coord_t  draw_y,
	output logic                      visible,
	output logic                      hsync,
	output logic                      vsync
);
	import duck_display_pkg::*;

	coord_t h_count;
	coord_t v_count;
	// raw syncs, active low, aligned with draw_x/draw_y
	logic hsync_raw;
	logic vsync_raw;
	// delay lines so syncs line up with registered rgb
	logic [PIXEL_LATENCY-1:0] hsync_pipe;
	logic [PIXEL_LATENCY-1:0] vsync_pipe;

	// ------------------------------------------------------------
	// raster counters
	// ------------------------------------------------------------
	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (h_count == H_TOTAL - 1)
		begin
			h_count <= '0;
			// end of line, step to next row or wrap frame
			if (v_count == V_TOTAL - 1)
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end
		else
		begin
			h_count <= h_count + 1'b1;
		end
	end

	assign draw_x = h_count;
	assign draw_y = v_count;

	// active picture area
	assign visible = (h_count < H_VISIBLE) && (v_count < V_VISIBLE);

	// sync windows
	assign hsync_raw = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));
	assign vsync_raw = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));

	// ------------------------------------------------------------
	// sync delay to match pixel pipeline
	// ------------------------------------------------------------
	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			// inactive level during reset
			hsync_pipe <= '1;
			vsync_pipe <= '1;
		end
		else
		begin
			hsync_pipe <= {hsync_pipe[PIXEL_LATENCY-2:0], hsync_raw};
			vsync_pipe <= {vsync_pipe[PIXEL_LATENCY-2:0], vsync_raw};
		end
	end

	assign hsync = hsync_pipe[PIXEL_LATENCY-1];
	assign vsync = vsync_pipe[PIXEL_LATENCY-1];

	// line counter never runs past the end of a line
	assert property (@(posedge vga_clk) disable iff (reset) draw_x < H_TOTAL);

endmodule

// ==== hw/duck_display_pkg.sv ====
package duck_display_pkg;

	// ------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------
	// screen coordinate or size
	typedef logic [9:0] coord_t;
	// one color channel
	typedef logic [3:0] color_t;
	// packed pixel, red in the top nibble
	typedef logic [11:0] rgb_t;
	// sprite palette index, 0 is see-through
	typedef logic [2:0] pal_index_t;
	// dog animation frame select
	typedef logic frame_t;
	// shots fired so far, 0 to 3
	typedef logic [1:0] shot_count_t;

	// ------------------------------------------------------------
	// 640x480 at 60 Hz raster
	// ------------------------------------------------------------
	localparam coord_t H_VISIBLE = 10'd640;
	localparam coord_t H_TOTAL = 10'd800;
	localparam coord_t V_VISIBLE = 10'd480;
	localparam coord_t V_TOTAL = 10'd525;
	localparam coord_t H_SYNC_START = 10'd656;
	localparam coord_t H_SYNC_END = 10'd752;
	localparam coord_t V_SYNC_START = 10'd490;
	localparam coord_t V_SYNC_END = 10'd492;
	// coordinate in, rgb out
	localparam int PIXEL_LATENCY = 2;

	// ------------------------------------------------------------
	// dog sprite
	// ------------------------------------------------------------
	localparam coord_t DOG_W = 10'd32;
	localparam coord_t DOG_H = 10'd24;
	localparam int DOG_FRAME_WORDS = 768;
	localparam int DOG_ROM_DEPTH = 1536;

	// ------------------------------------------------------------
	// ammo squares, y range is half open
	// ------------------------------------------------------------
	localparam coord_t SQ_Y0 = 10'd418;
	localparam coord_t SQ_Y1 = 10'd431;
	localparam coord_t SQ_W = 10'd9;
	// left edges of squares 1, 2, 3
	localparam logic [0:2][9:0] SQ_X0 = {10'd68, 10'd85, 10'd102};

	// ------------------------------------------------------------
	// scene colors
	// ------------------------------------------------------------
	localparam coord_t HORIZON_Y = 10'd360;
	localparam rgb_t SKY_COLOR = 12'h4AE;
	localparam rgb_t GRASS_COLOR = 12'h3A2;
	localparam rgb_t SQUARE_COLOR = 12'hAAA;
	localparam rgb_t CURSOR_COLOR = 12'hFFF;

	// entry 0 never shown, it marks transparent texels
	localparam logic [0:7][11:0] DOG_PALETTE = {
		12'h000, 12'h421, 12'h642, 12'h963,
		12'hC95, 12'hFDB, 12'h222, 12'hEEE
	};

endpackage
